// ==== host_cfg.svh ====
// Size and address-map macros for the host I/O block; include in RTL and testbench files
`ifndef HOST_CFG_SVH
`define HOST_CFG_SVH

// Number of cores served by the host block
`define HOST_NUM_CORES 4

// Word address layout {core index, register offset}
`define HOST_REG_OFS_W 2
`define HOST_CORE_IDX_W 2
`define HOST_ADR_W (`HOST_CORE_IDX_W + `HOST_REG_OFS_W)

// Data path
`define HOST_DATA_W 32
`define HOST_EXIT_CODE_W 16

// Register offsets inside one core's window
// Offsets 2 and 3 are unmapped
`define HOST_OFS_FINISH 0
`define HOST_OFS_TRACE 1

`endif

// ==== host_pkg.sv ====
// Shared register types for the host I/O block; import into any module that uses them
`default_nettype none

`include "host_cfg.svh"

package host_pkg;

  // Register addressed by the current access
  typedef enum logic [1:0] {
    REG_SEL_NONE   = 2'd0,
    REG_SEL_FINISH = 2'd1,
    REG_SEL_TRACE  = 2'd2
  } reg_sel_e;

  // Finish register layout
  typedef struct packed {
    logic                                        fail;
    logic                                        done;
    logic [`HOST_DATA_W-`HOST_EXIT_CODE_W-3:0]   rsvd;
    logic [`HOST_EXIT_CODE_W-1:0]                exit_code;
  } finish_word_t;

  // Trace-enable register layout, icache enable in bit 0
  typedef struct packed {
    logic [`HOST_DATA_W-5:0] rsvd;
    logic                    pc_profile;
    logic                    cmt_trace;
    logic                    dcache_trace;
    logic                    icache_trace;
  } trace_en_t;

  // One data word seen through either register layout
  typedef union packed {
    finish_word_t finish;
    trace_en_t    trace;
  } host_word_u;

endpackage

`default_nettype wire

// ==== host_cmd_decode.sv ====
// Wishbone request decoder; registers one per-core access for the register slices
`timescale 1ns/1ps
`default_nettype none

`include "host_cfg.svh"

module host_cmd_decode
  import host_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [`HOST_ADR_W-1:0]        wb_adr_i,
  input  logic [`HOST_DATA_W-1:0]       wb_dat_i,
  output logic                          acc_v_o,
  output logic [`HOST_CORE_IDX_W-1:0]   acc_core_o,
  output logic [`HOST_NUM_CORES-1:0]    acc_hit_o,
  output logic                          acc_we_o,
  output reg_sel_e                      acc_sel_o,
  output host_word_u                    acc_wdata_o
);

  localparam logic [`HOST_REG_OFS_W-1:0] OFS_FINISH = `HOST_OFS_FINISH;
  localparam logic [`HOST_REG_OFS_W-1:0] OFS_TRACE  = `HOST_OFS_TRACE;

  logic [`HOST_CORE_IDX_W-1:0] core_idx;
  logic [`HOST_REG_OFS_W-1:0]  reg_ofs;
  reg_sel_e                    sel_d;
  logic [`HOST_NUM_CORES-1:0]  hit_d;
  logic                        accept;
  logic                        ack_pend_q;

  assign core_idx = wb_adr_i[`HOST_ADR_W-1 -: `HOST_CORE_IDX_W];
  assign reg_ofs  = wb_adr_i[`HOST_REG_OFS_W-1:0];

  // Busy while the access stage or the ack cycle is in progress
  assign accept = wb_cyc_i & wb_stb_i & ~acc_v_o & ~ack_pend_q;

  always_comb
  begin
    case (reg_ofs)
      OFS_FINISH: sel_d = REG_SEL_FINISH;
      OFS_TRACE:  sel_d = REG_SEL_TRACE;
      default:    sel_d = REG_SEL_NONE;
    endcase
  end

  // Out-of-range core index leaves every strobe bit low
  always_comb
  begin
    for (int i = 0; i < `HOST_NUM_CORES; i++)
    begin
      hit_d[i] = accept && (int'(core_idx) == i);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      acc_v_o    <= 1'b0;
      ack_pend_q <= 1'b0;
      acc_hit_o  <= '0;
    end
    else
    begin
      acc_v_o    <= accept;
      ack_pend_q <= acc_v_o;
      acc_hit_o  <= hit_d;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      acc_core_o  <= core_idx;
      acc_we_o    <= wb_we_i;
      acc_sel_o   <= sel_d;
      acc_wdata_o <= wb_dat_i;
    end
  end

endmodule

`default_nettype wire

// ==== core_host_regs.sv ====
// Finish and trace-enable registers of one core; instantiated once per core by the top level
`timescale 1ns/1ps
`default_nettype none

`include "host_cfg.svh"

module core_host_regs
  import host_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       acc_hit_i,
  input  logic       acc_we_i,
  input  reg_sel_e   acc_sel_i,
  input  host_word_u acc_wdata_i,
  output host_word_u rdata_o,
  output logic       finish_o,
  output logic       fail_o,
  output logic       icache_trace_en_o,
  output logic       dcache_trace_en_o,
  output logic       cmt_trace_en_o,
  output logic       pc_profile_en_o
);

  logic                         done_q;
  logic                         fail_q;
  logic [`HOST_EXIT_CODE_W-1:0] exit_code_q;
  logic                         icache_en_q;
  logic                         dcache_en_q;
  logic                         cmt_en_q;
  logic                         pc_prof_en_q;
  logic                         fin_wr;
  logic                         trc_wr;

  // Finish is sticky, only the first write lands
  assign fin_wr = acc_hit_i & acc_we_i & (acc_sel_i == REG_SEL_FINISH) & ~done_q;
  assign trc_wr = acc_hit_i & acc_we_i & (acc_sel_i == REG_SEL_TRACE);

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      done_q      <= 1'b0;
      fail_q      <= 1'b0;
      exit_code_q <= '0;
    end
    else if (fin_wr)
    begin
      done_q      <= 1'b1;
      fail_q      <= acc_wdata_i.finish.fail;
      exit_code_q <= acc_wdata_i.finish.exit_code;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      icache_en_q  <= 1'b0;
      dcache_en_q  <= 1'b0;
      cmt_en_q     <= 1'b0;
      pc_prof_en_q <= 1'b0;
    end
    else if (trc_wr)
    begin
      icache_en_q  <= acc_wdata_i.trace.icache_trace;
      dcache_en_q  <= acc_wdata_i.trace.dcache_trace;
      cmt_en_q     <= acc_wdata_i.trace.cmt_trace;
      pc_prof_en_q <= acc_wdata_i.trace.pc_profile;
    end
  end

  // Read-back of the selected register, reserved bits zero
  always_comb
  begin
    rdata_o = '0;
    case (acc_sel_i)
      REG_SEL_FINISH:
      begin
        rdata_o.finish.fail      = fail_q;
        rdata_o.finish.done      = done_q;
        rdata_o.finish.exit_code = exit_code_q;
      end
      REG_SEL_TRACE:
      begin
        rdata_o.trace.icache_trace = icache_en_q;
        rdata_o.trace.dcache_trace = dcache_en_q;
        rdata_o.trace.cmt_trace    = cmt_en_q;
        rdata_o.trace.pc_profile   = pc_prof_en_q;
      end
      default:
      begin
        rdata_o = '0;
      end
    endcase
  end

  assign finish_o          = done_q;
  assign fail_o            = fail_q;
  assign icache_trace_en_o = icache_en_q;
  assign dcache_trace_en_o = dcache_en_q;
  assign cmt_trace_en_o    = cmt_en_q;
  assign pc_profile_en_o   = pc_prof_en_q;

endmodule

`default_nettype wire

// ==== host_resp_mux.sv ====
// Response collector; returns the Wishbone read data and ack and the finish summaries
`timescale 1ns/1ps
`default_nettype none

`include "host_cfg.svh"

module host_resp_mux
  import host_pkg::*;
(
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  input  logic                                    acc_v_i,
  input  logic [`HOST_CORE_IDX_W-1:0]             acc_core_i,
  input  logic [`HOST_NUM_CORES-1:0]              acc_hit_i,
  input  host_word_u [`HOST_NUM_CORES-1:0]        core_rdata_i,
  input  logic [`HOST_NUM_CORES-1:0]              core_finish_i,
  input  logic [`HOST_NUM_CORES-1:0]              core_fail_i,
  output logic                                    wb_ack_o,
  output logic [`HOST_DATA_W-1:0]                 wb_dat_o,
  output logic                                    all_finished_o,
  output logic                                    any_fail_o
);

  host_word_u sel_word;

  // Zero when the access hit no core
  always_comb
  begin
    if (acc_v_i && (|acc_hit_i))
    begin
      sel_word = core_rdata_i[acc_core_i];
    end
    else
    begin
      sel_word = '0;
    end
  end

  // Ack one cycle after the access stage
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
    end
    else
    begin
      wb_ack_o <= acc_v_i;
      wb_dat_o <= sel_word;
    end
  end

  // Fail only counts for a core that has finished
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      all_finished_o <= 1'b0;
      any_fail_o     <= 1'b0;
    end
    else
    begin
      all_finished_o <= &core_finish_i;
      any_fail_o     <= |(core_finish_i & core_fail_i);
    end
  end

endmodule

`default_nettype wire

// ==== host_io_top.sv ====
// Host I/O control block top level; Wishbone slave with per-core finish and trace registers
`timescale 1ns/1ps
`default_nettype none

`include "host_cfg.svh"

module host_io_top
  import host_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [`HOST_ADR_W-1:0]      wb_adr_i,
  input  logic [`HOST_DATA_W-1:0]     wb_dat_i,
  output logic                        wb_ack_o,
  output logic [`HOST_DATA_W-1:0]     wb_dat_o,
  output logic [`HOST_NUM_CORES-1:0]  finish_o,
  output logic [`HOST_NUM_CORES-1:0]  fail_o,
  output logic [`HOST_NUM_CORES-1:0]  icache_trace_en_o,
  output logic [`HOST_NUM_CORES-1:0]  dcache_trace_en_o,
  output logic [`HOST_NUM_CORES-1:0]  cmt_trace_en_o,
  output logic [`HOST_NUM_CORES-1:0]  pc_profile_en_o,
  output logic                        all_finished_o,
  output logic                        any_fail_o
);

  logic                                acc_v;
  logic [`HOST_CORE_IDX_W-1:0]         acc_core;
  logic [`HOST_NUM_CORES-1:0]          acc_hit;
  logic                                acc_we;
  reg_sel_e                            acc_sel;
  host_word_u                          acc_wdata;
  host_word_u [`HOST_NUM_CORES-1:0]    core_rdata;

  host_cmd_decode u_host_cmd_decode (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .acc_v_o     (acc_v),
    .acc_core_o  (acc_core),
    .acc_hit_o   (acc_hit),
    .acc_we_o    (acc_we),
    .acc_sel_o   (acc_sel),
    .acc_wdata_o (acc_wdata)
  );

  for (genvar i = 0; i < `HOST_NUM_CORES; i++)
  begin : g_core
    core_host_regs u_core_host_regs (
      .clk_i             (clk_i),
      .arst_n_i          (arst_n_i),
      .acc_hit_i         (acc_hit[i]),
      .acc_we_i          (acc_we),
      .acc_sel_i         (acc_sel),
      .acc_wdata_i       (acc_wdata),
      .rdata_o           (core_rdata[i]),
      .finish_o          (finish_o[i]),
      .fail_o            (fail_o[i]),
      .icache_trace_en_o (icache_trace_en_o[i]),
      .dcache_trace_en_o (dcache_trace_en_o[i]),
      .cmt_trace_en_o    (cmt_trace_en_o[i]),
      .pc_profile_en_o   (pc_profile_en_o[i])
    );
  end

  host_resp_mux u_host_resp_mux (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .acc_v_i        (acc_v),
    .acc_core_i     (acc_core),
    .acc_hit_i      (acc_hit),
    .core_rdata_i   (core_rdata),
    .core_finish_i  (finish_o),
    .core_fail_i    (fail_o),
    .wb_ack_o       (wb_ack_o),
    .wb_dat_o       (wb_dat_o),
    .all_finished_o (all_finished_o),
    .any_fail_o     (any_fail_o)
  );

endmodule

`default_nettype wire

// ==== tb_host_io.sv ====
// Self-checking testbench for host_io_top; runs a table of Wishbone accesses against a reference model
`timescale 1ns/1ps
`default_nettype none

`include "host_cfg.svh"

module tb_host_io;

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 10;
  localparam int N_RANDOM    = 16;
  localparam int CYC_PER_ROW = 4;
  localparam int MARGIN      = 40;
  localparam int NC          = `HOST_NUM_CORES;
  localparam int ADR_W       = `HOST_ADR_W;
  localparam int OFS_W       = `HOST_REG_OFS_W;
  localparam int CODE_W      = `HOST_EXIT_CODE_W;

  // One access and the word it must read back
  typedef struct packed {
    logic        wr;
    logic [7:0]  core;
    logic [7:0]  ofs;
    logic [31:0] wdata;
    logic [31:0] exp;
    logic        from_model;
  } row_t;

  logic                     clk_i;
  logic                     arst_n_i;
  logic                     wb_cyc_i;
  logic                     wb_stb_i;
  logic                     wb_we_i;
  logic [`HOST_ADR_W-1:0]   wb_adr_i;
  logic [`HOST_DATA_W-1:0]  wb_dat_i;
  logic                     wb_ack_o;
  logic [`HOST_DATA_W-1:0]  wb_dat_o;
  logic [NC-1:0]            finish_o;
  logic [NC-1:0]            fail_o;
  logic [NC-1:0]            icache_trace_en_o;
  logic [NC-1:0]            dcache_trace_en_o;
  logic [NC-1:0]            cmt_trace_en_o;
  logic [NC-1:0]            pc_profile_en_o;
  logic                     all_finished_o;
  logic                     any_fail_o;

  row_t rows[$];
  bit   rows_built = 1'b0;
  int   timeout_cycles;
  int   cycle_cnt;

  // Reference model of every core's registers
  logic              m_done [NC];
  logic              m_fail [NC];
  logic [CODE_W-1:0] m_code [NC];
  logic [3:0]        m_trace [NC];

  host_io_top u_host_io_top (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .wb_cyc_i          (wb_cyc_i),
    .wb_stb_i          (wb_stb_i),
    .wb_we_i           (wb_we_i),
    .wb_adr_i          (wb_adr_i),
    .wb_dat_i          (wb_dat_i),
    .wb_ack_o          (wb_ack_o),
    .wb_dat_o          (wb_dat_o),
    .finish_o          (finish_o),
    .fail_o            (fail_o),
    .icache_trace_en_o (icache_trace_en_o),
    .dcache_trace_en_o (dcache_trace_en_o),
    .cmt_trace_en_o    (cmt_trace_en_o),
    .pc_profile_en_o   (pc_profile_en_o),
    .all_finished_o    (all_finished_o),
    .any_fail_o        (any_fail_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("ERROR: time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  function automatic logic [31:0] model_read(input logic [7:0] core, input logic [7:0] ofs);
    logic [31:0] w;
    w = '0;
    if (core < NC)
    begin
      if (ofs == `HOST_OFS_FINISH)
      begin
        w[31]         = m_fail[core];
        w[30]         = m_done[core];
        w[CODE_W-1:0] = m_code[core];
      end
      else if (ofs == `HOST_OFS_TRACE)
      begin
        w[3:0] = m_trace[core];
      end
    end
    return w;
  endfunction

  // Finish takes the first write only
  task automatic model_write(input logic [7:0] core, input logic [7:0] ofs,
                             input logic [31:0] d);
    if (core < NC)
    begin
      if (ofs == `HOST_OFS_FINISH && !m_done[core])
      begin
        m_done[core] = 1'b1;
        m_fail[core] = d[31];
        m_code[core] = d[CODE_W-1:0];
      end
      else if (ofs == `HOST_OFS_TRACE)
      begin
        m_trace[core] = d[3:0];
      end
    end
  endtask

  task automatic add_row(input logic wr, input int core, input int ofs,
                         input logic [31:0] wdata, input logic [31:0] exp);
    rows.push_back({wr, 8'(core), 8'(ofs), wdata, exp, 1'b0});
  endtask

  task automatic build_table();
    logic [31:0] d;
    for (int c = 0; c < NC; c++)
    begin
      for (int o = 0; o < 4; o++)
      begin
        add_row(1'b0, c, o, 32'h0, 32'h0);
      end
    end
    add_row(1'b1, 1, 1, 32'hffff_fff5, 32'h0);
    add_row(1'b0, 1, 1, 32'h0, 32'h0000_0005);
    add_row(1'b1, 2, 1, 32'h0000_000a, 32'h0);
    add_row(1'b0, 2, 1, 32'h0, 32'h0000_000a);
    // Unmapped offsets take nothing
    add_row(1'b1, 1, 2, 32'hffff_ffff, 32'h0);
    add_row(1'b1, 2, 3, 32'hffff_ffff, 32'h0);
    add_row(1'b0, 1, 3, 32'h0, 32'h0);
    add_row(1'b1, 1, 0, 32'h0000_0001, 32'h0);
    add_row(1'b0, 1, 0, 32'h0, 32'h4000_0001);
    add_row(1'b1, 2, 0, 32'h3fff_0002, 32'h0);
    add_row(1'b0, 2, 0, 32'h0, 32'h4000_0002);
    add_row(1'b1, 0, 0, 32'h8000_1234, 32'h0);
    add_row(1'b0, 0, 0, 32'h0, 32'hc000_1234);
    // Second finish write must not land
    add_row(1'b1, 0, 0, 32'h0000_5678, 32'hc000_1234);
    add_row(1'b0, 0, 0, 32'h0, 32'hc000_1234);
    add_row(1'b1, 3, 1, 32'h0000_000f, 32'h0);
    add_row(1'b0, 3, 1, 32'h0, 32'h0000_000f);
    add_row(1'b1, 3, 0, 32'h0000_00ff, 32'h0);
    add_row(1'b0, 3, 0, 32'h0, 32'h4000_00ff);
    add_row(1'b1, 1, 1, 32'h0, 32'h0000_0005);
    add_row(1'b0, 1, 1, 32'h0, 32'h0);
    for (int i = 0; i < N_RANDOM; i++)
    begin
      d = $urandom;
      rows.push_back({($urandom % 2) == 1, 8'($urandom % 4), 8'($urandom % 4), d, 32'h0, 1'b1});
    end
  endtask

  task automatic check_outputs();
    logic [NC-1:0] e_fin;
    logic [NC-1:0] e_fail;
    logic [NC-1:0] e_ic;
    logic [NC-1:0] e_dc;
    logic [NC-1:0] e_cm;
    logic [NC-1:0] e_pc;
    for (int c = 0; c < NC; c++)
    begin
      e_fin[c]  = m_done[c];
      e_fail[c] = m_fail[c];
      e_ic[c]   = m_trace[c][0];
      e_dc[c]   = m_trace[c][1];
      e_cm[c]   = m_trace[c][2];
      e_pc[c]   = m_trace[c][3];
    end
    check_eq(32'(wb_ack_o), 32'h0, "wb_ack_o");
    check_eq(32'(finish_o), 32'(e_fin), "finish_o");
    check_eq(32'(fail_o), 32'(e_fail), "fail_o");
    check_eq(32'(icache_trace_en_o), 32'(e_ic), "icache_trace_en_o");
    check_eq(32'(dcache_trace_en_o), 32'(e_dc), "dcache_trace_en_o");
    check_eq(32'(cmt_trace_en_o), 32'(e_cm), "cmt_trace_en_o");
    check_eq(32'(pc_profile_en_o), 32'(e_pc), "pc_profile_en_o");
    check_eq(32'(all_finished_o), 32'(&e_fin), "all_finished_o");
    check_eq(32'(any_fail_o), 32'(|(e_fin & e_fail)), "any_fail_o");
  endtask

  initial
  begin : main
    row_t        r;
    logic [31:0] exp;
    int          lat;
    arst_n_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    for (int c = 0; c < NC; c++)
    begin
      m_done[c]  = 1'b0;
      m_fail[c]  = 1'b0;
      m_code[c]  = '0;
      m_trace[c] = '0;
    end
    void'($urandom(32'h56ab));
    build_table();
    timeout_cycles = rows.size() * CYC_PER_ROW + RST_CYCLES + MARGIN;
    rows_built = 1'b1;

    repeat (RST_CYCLES) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    check_outputs();
    check_eq(wb_dat_o, 32'h0, "wb_dat_o after reset");

    foreach (rows[i])
    begin
      r   = rows[i];
      exp = r.from_model ? model_read(r.core, r.ofs) : r.exp;
      @(posedge clk_i);
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      wb_we_i  <= r.wr;
      wb_adr_i <= ADR_W'((int'(r.core) << OFS_W) | int'(r.ofs));
      wb_dat_i <= r.wr ? r.wdata : 32'h0;
      // Latency counted in clock edges after the request edge
      lat = 0;
      @(negedge clk_i);
      while (!wb_ack_o)
      begin
        lat++;
        @(negedge clk_i);
      end
      check_eq(32'(lat), 32'd2, "ack latency");
      check_eq(wb_dat_o, exp, $sformatf("wb_dat_o row %0d", i));
      @(posedge clk_i);
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
      @(negedge clk_i);
      if (r.wr)
      begin
        model_write(r.core, r.ofs, r.wdata);
      end
      check_outputs();
    end

    $display("STATUS: PASS");
    $finish;
  end

  initial
  begin : watchdog
    cycle_cnt = 0;
    wait (rows_built);
    while (cycle_cnt < timeout_cycles)
    begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: the run did not complete within %0d clock cycles", timeout_cycles);
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
host_pkg.sv
host_cmd_decode.sv
core_host_regs.sv
host_resp_mux.sv
host_io_top.sv
tb_host_io.sv
